//--- flist.f
+incdir+include
verilog/dcache_pkg.sv
verilog/dc_arbiter.sv
verilog/dc_tag_store.sv
verilog/dc_data_store.sv
verilog/dc_hit_checker.sv
verilog/dc_evict_gen.sv
verilog/dc_wr_data_gen.sv
verilog/dc_rd_data_gen.sv
verilog/dcache.sv
sim/mem_model.sv
sim/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_dcache \
  -Mdir obj_dir -o sim_dcache
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "TEST PASSED" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- sim/tb_dcache.sv
// ##############################
// Data cache testbench
// Directed and random loads/stores vs shadow memory
// ##############################

`timescale 1ns/100ps

module tb_dcache import dcache_pkg::*; ();

  logic  clk = 1'b0;
  logic  rst_n;
  logic  v_mem_read, wr_fifo_empty, wr_fifo_to_be_full, mem_conflict;
  addr_t mem_rd_addr, mem_wr_addr, dc_miss_addr, dc_evict_addr;
  size_t mem_rd_size, mem_wr_size;
  data_t mem_wr_data, mem_rd_data;
  logic  mem_rd_ready, mem_wr_done, mem_rd_busy, mem_wr_busy;
  logic  dc_miss, dc_evict, dc_miss_ack, evict_bad;
  line_t dc_evict_data, dc_data_fill, exp_evict_line;

  logic [7:0] shadow [32768];
  logic       dirty_lines [2048];
  int         miss_count;
  int         evict_count;
  addr_t      last_evict_addr;

  always #4 clk = ~clk;

  dcache DUT (.*);

  mem_model u_mem_model (.*);

  task automatic fail_now(string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  function automatic line_t line_of(addr_t a);
    line_t l;
    for (int b = 0; b < 16; b++) begin
      l[b*8 +: 8] = shadow[{a[14:4], 4'b0000} + b];
    end
    return l;
  endfunction

  function automatic data_t expect_read(addr_t a, size_t sz);
    data_t r;
    r = '0;
    for (int i = 0; i < (1 << sz); i++) begin
      r[i*8 +: 8] = shadow[a[14:0] + i];
    end
    return r;
  endfunction

  // Expected victim contents, taken once inputs have settled
  always @(negedge clk) begin
    #1;
    exp_evict_line = line_of(dc_evict_addr);
  end

  always @(negedge clk) begin
    if (rst_n) begin
      a_evict_ok: assert (!evict_bad) else fail_now("evicted line differs from shadow");
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      a_rd_busy: assert (!mem_rd_busy || (v_mem_read && !mem_rd_ready))
        else fail_now("read busy while no read is waiting");
      a_wr_busy: assert (!mem_wr_busy || (!wr_fifo_empty && !mem_wr_done))
        else fail_now("write busy while no write is waiting");
      if (mem_rd_ready) begin
        a_read: assert (mem_rd_data == expect_read(mem_rd_addr, mem_rd_size))
          else fail_now("load data mismatch");
      end
      if (mem_wr_done) begin
        for (int i = 0; i < (1 << mem_wr_size); i++) begin
          shadow[mem_wr_addr[14:0] + i] = mem_wr_data[i*8 +: 8];
        end
        dirty_lines[mem_wr_addr[14:4]] = 1'b1;
      end
      if (dc_miss) begin
        // Writes queued by this stimulus always win the grant
        a_miss_addr: assert (dc_miss_addr ==
          {(wr_fifo_empty ? mem_rd_addr[31:4] : mem_wr_addr[31:4]), 4'b0000})
          else fail_now("miss address is not the granted line");
        a_miss_busy: assert (wr_fifo_empty ? mem_rd_busy : mem_wr_busy)
          else fail_now("busy low during an outstanding miss");
      end
      if (dc_miss_ack) begin
        miss_count++;
        a_fill: assert (dc_data_fill == line_of(dc_miss_addr))
          else fail_now("fill line differs from backing line");
        if (dc_evict) begin
          a_evict_dirty: assert (dirty_lines[dc_evict_addr[14:4]])
            else fail_now("clean line was evicted");
          dirty_lines[dc_evict_addr[14:4]] = 1'b0;
          evict_count++;
          last_evict_addr = dc_evict_addr;
        end
        dirty_lines[dc_miss_addr[14:4]] = 1'b0;
      end
    end
  end

  // Called on a falling edge, returns on a falling edge
  task automatic do_access(logic is_write, addr_t a, size_t sz, data_t d);
    if (is_write) begin
      mem_wr_addr   = a;
      mem_wr_size   = sz;
      mem_wr_data   = d;
      wr_fifo_empty = 1'b0;
    end else begin
      mem_rd_addr = a;
      mem_rd_size = sz;
      v_mem_read  = 1'b1;
    end
    do @(posedge clk); while (!(mem_rd_ready || mem_wr_done));
    @(negedge clk);
    v_mem_read    = 1'b0;
    wr_fifo_empty = 1'b1;
  endtask

  task automatic check_write_priority(addr_t ra, addr_t wa, logic by_conflict);
    logic wr_seen;
    logic rd_seen;
    wr_seen = 1'b0;
    rd_seen = 1'b0;
    mem_rd_addr = ra;
    mem_rd_size = 2'd3;
    v_mem_read  = 1'b1;
    mem_wr_addr = wa;
    mem_wr_size = 2'd2;
    mem_wr_data = 64'h0bad_cafe_1234_5678;
    wr_fifo_empty      = 1'b0;
    wr_fifo_to_be_full = !by_conflict;
    mem_conflict       = by_conflict;
    while (!rd_seen) begin
      @(posedge clk);
      if (mem_rd_ready) begin
        a_order: assert (wr_seen) else fail_now("read completed before queued write");
        rd_seen = 1'b1;
      end
      if (mem_wr_done) begin
        wr_seen = 1'b1;
      end
      @(negedge clk);
      if (wr_seen) begin
        wr_fifo_empty      = 1'b1;
        wr_fifo_to_be_full = 1'b0;
        mem_conflict       = 1'b0;
      end
      if (rd_seen) begin
        v_mem_read = 1'b0;
      end
    end
  endtask

  initial begin
    #(400 * 20 * 8);
    $display("Watchdog expired, the cache stopped completing accesses");
    $display("TEST FAILED");
    $fatal(1);
  end

  initial begin
    int    n;
    int    misses_before;
    size_t sz;
    addr_t a;
    void'($urandom(1407));
    for (int i = 0; i < 32768; i++) begin
      shadow[i] = 8'(i * 3 + (i >> 8));
    end
    for (int i = 0; i < 2048; i++) begin
      dirty_lines[i] = 1'b0;
    end
    miss_count = 0;
    evict_count = 0;
    last_evict_addr = '0;
    rst_n = 1'b0;
    v_mem_read = 1'b0;
    wr_fifo_empty = 1'b1;
    wr_fifo_to_be_full = 1'b0;
    mem_conflict = 1'b0;
    mem_rd_addr = '0;
    mem_rd_size = '0;
    mem_wr_addr = '0;
    mem_wr_size = '0;
    mem_wr_data = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    a_reset_quiet: assert (!mem_rd_ready && !mem_wr_done && !mem_rd_busy && !mem_wr_busy &&
                           !dc_miss && !dc_evict)
      else fail_now("control output high after reset");
    @(negedge clk);

    // Lines A, B and C share set 1
    do_access(1'b0, 32'h0010, 2'd3, '0);
    do_access(1'b1, 32'h0118, 2'd2, 64'h1122_3344);
    do_access(1'b0, 32'h0010, 2'd2, '0);
    do_access(1'b0, 32'h0210, 2'd1, '0);
    a_lru: assert (evict_count == 1 && last_evict_addr == 32'h0110)
      else fail_now("miss for third line did not evict line B");
    misses_before = miss_count;
    do_access(1'b0, 32'h0118, 2'd2, '0);
    a_refetch: assert (miss_count == misses_before + 1)
      else fail_now("line B was not refetched");

    // Store then load every size at every aligned offset
    for (int s = 0; s < 4; s++) begin
      for (int off = 0; off < 16; off += (1 << s)) begin
        a = 32'h0500 + off;
        do_access(1'b1, a, size_t'(s), {$urandom, $urandom});
        do_access(1'b0, a, size_t'(s), '0);
      end
    end

    check_write_priority(32'h0700, 32'h0320, 1'b0);
    // Read overlaps the queued store
    check_write_priority(32'h0640, 32'h0644, 1'b1);

    for (int k = 0; k < 200; k++) begin
      n = $urandom % 48;
      sz = size_t'($urandom % 4);
      a = ((n / 16 + 4) << 8) | ((n % 16) << 4);
      a = a | (($urandom % 16) & ~((1 << sz) - 1));
      do_access(1'($urandom % 2), a, sz, {$urandom, $urandom});
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- sim/mem_model.sv
// ##############################
// Memory side model
// Answers misses, checks evicted lines
// ##############################

`timescale 1ns/100ps

module mem_model import dcache_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  dc_miss,
  input  addr_t dc_miss_addr,
  input  logic  dc_evict,
  input  addr_t dc_evict_addr,
  input  line_t dc_evict_data,
  input  line_t exp_evict_line,
  output logic  dc_miss_ack,
  output line_t dc_data_fill,
  output logic  evict_bad
);

  localparam int FILL_DELAY = 2;

  logic [7:0] backing [32768];
  int         wait_cnt;

  // Same pattern as the testbench shadow
  initial begin
    for (int i = 0; i < 32768; i++) begin
      backing[i] = 8'(i * 3 + (i >> 8));
    end
  end

  function automatic line_t backing_line(addr_t a);
    line_t l;
    for (int b = 0; b < 16; b++) begin
      l[b*8 +: 8] = backing[{a[14:4], 4'b0000} + b];
    end
    return l;
  endfunction

  // Ack after a short wait, one cycle wide
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dc_miss_ack  <= 1'b0;
      dc_data_fill <= '0;
      wait_cnt     <= 0;
    end else if (dc_miss_ack || !dc_miss) begin
      dc_miss_ack <= 1'b0;
      wait_cnt    <= 0;
    end else if (wait_cnt == FILL_DELAY) begin
      dc_miss_ack  <= 1'b1;
      dc_data_fill <= backing_line(dc_miss_addr);
    end else begin
      wait_cnt <= wait_cnt + 1;
    end
  end

  // Write-back of the dirty victim on the ack edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      evict_bad <= 1'b0;
    end else if (dc_miss_ack && dc_evict) begin
      a_evict_data: assert (dc_evict_data == exp_evict_line) else evict_bad <= 1'b1;
      for (int b = 0; b < 16; b++) begin
        backing[{dc_evict_addr[14:4], 4'b0000} + b] = dc_evict_data[b*8 +: 8];
      end
    end
  end

endmodule

//--- verilog/dcache.sv
// ##############################
// Two-way data cache top
// 16 sets of 16-byte lines, miss/evict handshake
// ##############################

`timescale 1ns/100ps

`include "dcache_config.svh"

module dcache import dcache_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  v_mem_read,
  input  logic  wr_fifo_empty,
  input  logic  wr_fifo_to_be_full,
  input  logic  mem_conflict,
  input  addr_t mem_rd_addr,
  input  size_t mem_rd_size,
  input  addr_t mem_wr_addr,
  input  size_t mem_wr_size,
  input  data_t mem_wr_data,
  output data_t mem_rd_data,
  output logic  mem_rd_ready,
  output logic  mem_wr_done,
  output logic  mem_rd_busy,
  output logic  mem_wr_busy,
  output logic  dc_miss,
  output addr_t dc_miss_addr,
  output logic  dc_evict,
  output addr_t dc_evict_addr,
  output line_t dc_evict_data,
  input  logic  dc_miss_ack,
  input  line_t dc_data_fill
);

  logic       ren, wen, access_done;
  addr_t      rw_addr;
  tag_t       phy_tag;
  index_t     index;
  offset_t    offset;
  tag_t       tag1, tag2;
  logic       valid1, valid2, dirty1, dirty2, repl_way2;
  logic       tag_eq1, tag_eq2, dc_hit;
  logic       evict_way1, evict_way2;
  line_t      rd_line1, rd_line2, wr_data;
  byte_mask_t wr_mask1, wr_mask2;

  // Read address only while the read owns the cache
  assign rw_addr = ren ? mem_rd_addr : mem_wr_addr;
  assign phy_tag = rw_addr[`DC_TAG_LSB +: `DC_TAG_W];
  assign index   = rw_addr[`DC_TAG_LSB-1 -: `DC_INDEX_W];
  assign offset  = rw_addr[$bits(offset_t)-1:0];

  dc_arbiter u_dc_arbiter (
    .clk(clk), .rst_n(rst_n), .v_mem_read(v_mem_read),
    .wr_fifo_empty(wr_fifo_empty), .wr_fifo_to_be_full(wr_fifo_to_be_full),
    .mem_conflict(mem_conflict), .access_done(access_done),
    .ren(ren), .wen(wen)
  );

  // Fill on the ack edge, store hits mark the line dirty
  dc_tag_store u_dc_tag_store (
    .clk(clk), .rst_n(rst_n), .index(index),
    .fill_way1(dc_miss_ack & evict_way1), .fill_way2(dc_miss_ack & evict_way2),
    .fill_tag(phy_tag),
    .dirty_set1(wen & dc_hit & tag_eq1), .dirty_set2(wen & dc_hit & tag_eq2),
    .touch_way1(dc_hit & tag_eq1), .touch_way2(dc_hit & tag_eq2),
    .tag1(tag1), .tag2(tag2), .valid1(valid1), .valid2(valid2),
    .dirty1(dirty1), .dirty2(dirty2), .repl_way2(repl_way2)
  );

  dc_data_store u_dc_data_store (
    .clk(clk), .index(index), .wr_data(wr_data),
    .wr_mask1(wr_mask1), .wr_mask2(wr_mask2),
    .rd_line1(rd_line1), .rd_line2(rd_line2)
  );

  dc_hit_checker u_dc_hit_checker (
    .phy_tag(phy_tag), .tag1(tag1), .tag2(tag2), .valid1(valid1), .valid2(valid2),
    .ren(ren), .wen(wen), .dc_miss_ack(dc_miss_ack),
    .tag_eq1(tag_eq1), .tag_eq2(tag_eq2), .dc_hit(dc_hit), .dc_miss(dc_miss),
    .mem_rd_ready(mem_rd_ready), .mem_wr_done(mem_wr_done),
    .mem_rd_busy(mem_rd_busy), .mem_wr_busy(mem_wr_busy), .access_done(access_done)
  );

  dc_evict_gen u_dc_evict_gen (
    .dc_miss(dc_miss), .phy_tag(phy_tag), .tag1(tag1), .tag2(tag2), .index(index),
    .valid1(valid1), .valid2(valid2), .dirty1(dirty1), .dirty2(dirty2),
    .repl_way2(repl_way2), .rd_line1(rd_line1), .rd_line2(rd_line2),
    .evict_way1(evict_way1), .evict_way2(evict_way2), .dc_evict(dc_evict),
    .dc_miss_addr(dc_miss_addr), .dc_evict_addr(dc_evict_addr),
    .dc_evict_data(dc_evict_data)
  );

  dc_wr_data_gen u_dc_wr_data_gen (
    .wen(wen), .tag_eq1(tag_eq1), .tag_eq2(tag_eq2), .dc_miss_ack(dc_miss_ack),
    .evict_way1(evict_way1), .evict_way2(evict_way2), .mem_wr_data(mem_wr_data),
    .mem_wr_size(mem_wr_size), .offset(offset), .dc_data_fill(dc_data_fill),
    .wr_data(wr_data), .wr_mask1(wr_mask1), .wr_mask2(wr_mask2)
  );

  dc_rd_data_gen u_dc_rd_data_gen (
    .rd_line1(rd_line1), .rd_line2(rd_line2), .tag_eq2(tag_eq2), .offset(offset),
    .mem_rd_size(mem_rd_size), .mem_rd_data(mem_rd_data)
  );

  // Only the low 32 KB is cacheable
  a_cached_range: assert property (@(posedge clk) disable iff (!rst_n)
    (ren || wen) |-> (rw_addr[`DC_ADDR_W-1:`DC_CACHED_MSB+1] == '0));

endmodule

//--- verilog/dc_rd_data_gen.sv
// ##############################
// Read data generator
// Way select and byte alignment for loads
// ##############################

`timescale 1ns/100ps

module dc_rd_data_gen import dcache_pkg::*; (
  input  line_t   rd_line1,
  input  line_t   rd_line2,
  input  logic    tag_eq2,
  input  offset_t offset,
  input  size_t   mem_rd_size,
  output data_t   mem_rd_data
);

  line_t sel_line;
  line_t shifted;

  assign sel_line = tag_eq2 ? rd_line2 : rd_line1;

  // Requested bytes down to bit 0
  assign shifted = sel_line >> {offset, 3'b000};

  always_comb begin
    case (mem_rd_size)
      2'd0:    mem_rd_data = data_t'(shifted[7:0]);
      2'd1:    mem_rd_data = data_t'(shifted[15:0]);
      2'd2:    mem_rd_data = data_t'(shifted[31:0]);
      default: mem_rd_data = shifted[63:0];
    endcase
  end

endmodule

//--- verilog/dc_wr_data_gen.sv
// ##############################
// Write data generator
// Line data and byte masks for stores and fills
// ##############################

`timescale 1ns/100ps

module dc_wr_data_gen import dcache_pkg::*; (
  input  logic       wen,
  input  logic       tag_eq1,
  input  logic       tag_eq2,
  input  logic       dc_miss_ack,
  input  logic       evict_way1,
  input  logic       evict_way2,
  input  data_t      mem_wr_data,
  input  size_t      mem_wr_size,
  input  offset_t    offset,
  input  line_t      dc_data_fill,
  output line_t      wr_data,
  output byte_mask_t wr_mask1,
  output byte_mask_t wr_mask2
);

  byte_mask_t size_mask;
  byte_mask_t store_mask;
  logic       store_hit1;
  logic       store_hit2;

  always_comb begin
    case (mem_wr_size)
      2'd0:    size_mask = byte_mask_t'(16'h0001);
      2'd1:    size_mask = byte_mask_t'(16'h0003);
      2'd2:    size_mask = byte_mask_t'(16'h000f);
      default: size_mask = byte_mask_t'(16'h00ff);
    endcase
  end

  // Aligned access never runs past the end of the line
  assign store_mask = size_mask << offset;

  assign store_hit1 = wen & tag_eq1;
  assign store_hit2 = wen & tag_eq2;

  assign wr_data = dc_miss_ack ? dc_data_fill : (line_t'(mem_wr_data) << {offset, 3'b000});

  // Fill replaces the whole victim line
  assign wr_mask1 = dc_miss_ack ? {$bits(byte_mask_t){evict_way1}} :
                    (store_hit1 ? store_mask : '0);
  assign wr_mask2 = dc_miss_ack ? {$bits(byte_mask_t){evict_way2}} :
                    (store_hit2 ? store_mask : '0);

endmodule

//--- verilog/dc_evict_gen.sv
// ##############################
// Eviction generator
// Victim way, eviction and miss address
// ##############################

`timescale 1ns/100ps

module dc_evict_gen import dcache_pkg::*; (
  input  logic   dc_miss,
  input  tag_t   phy_tag,
  input  tag_t   tag1,
  input  tag_t   tag2,
  input  index_t index,
  input  logic   valid1,
  input  logic   valid2,
  input  logic   dirty1,
  input  logic   dirty2,
  input  logic   repl_way2,
  input  line_t  rd_line1,
  input  line_t  rd_line2,
  output logic   evict_way1,
  output logic   evict_way2,
  output logic   dc_evict,
  output addr_t  dc_miss_addr,
  output addr_t  dc_evict_addr,
  output line_t  dc_evict_data
);

  tag_t victim_tag;
  logic victim_dirty;

  // Empty way 1, then empty way 2, then the LRU choice
  assign evict_way1 = !valid1 | (valid2 & !repl_way2);
  assign evict_way2 = !evict_way1;

  assign victim_tag   = evict_way1 ? tag1 : tag2;
  assign victim_dirty = evict_way1 ? (valid1 & dirty1) : (valid2 & dirty2);

  // Clean victims are dropped silently
  assign dc_evict      = dc_miss & victim_dirty;
  assign dc_evict_data = evict_way1 ? rd_line1 : rd_line2;

  // Line-aligned, bits above the cached space stay zero
  assign dc_miss_addr  = addr_t'({phy_tag, index, offset_t'(0)});
  assign dc_evict_addr = addr_t'({victim_tag, index, offset_t'(0)});

endmodule

//--- verilog/dc_hit_checker.sv
// ##############################
// Hit checker
// Tag compare, hit/miss and completion
// ##############################

`timescale 1ns/100ps

module dc_hit_checker import dcache_pkg::*; (
  input  tag_t phy_tag,
  input  tag_t tag1,
  input  tag_t tag2,
  input  logic valid1,
  input  logic valid2,
  input  logic ren,
  input  logic wen,
  input  logic dc_miss_ack,
  output logic tag_eq1,
  output logic tag_eq2,
  output logic dc_hit,
  output logic dc_miss,
  output logic mem_rd_ready,
  output logic mem_wr_done,
  output logic mem_rd_busy,
  output logic mem_wr_busy,
  output logic access_done
);

  logic granted;

  assign granted = ren | wen;

  assign tag_eq1 = valid1 && (tag1 == phy_tag);
  assign tag_eq2 = valid2 && (tag2 == phy_tag);

  assign dc_hit  = granted & (tag_eq1 | tag_eq2);
  assign dc_miss = granted & !(tag_eq1 | tag_eq2);

  // Single-cycle pulses on the hit that ends the access
  assign mem_rd_ready = ren & dc_hit;
  assign mem_wr_done  = wen & dc_hit;
  assign access_done  = mem_rd_ready | mem_wr_done;

  assign mem_rd_busy = ren & !dc_hit;
  assign mem_wr_busy = wen & !dc_hit;

  // A line lives in at most one way
  // Fills only arrive while an access holds the grant
  always_comb begin
    a_one_way: assert final (!(tag_eq1 && tag_eq2));
    a_ack_in_grant: assert final (!dc_miss_ack || granted);
  end

endmodule

//--- verilog/dc_data_store.sv
// ##############################
// Data store
// Two ways of lines, byte-masked writes
// ##############################

`timescale 1ns/100ps

`include "dcache_config.svh"

module dc_data_store import dcache_pkg::*; (
  input  logic       clk,
  input  index_t     index,
  input  line_t      wr_data,
  input  byte_mask_t wr_mask1,
  input  byte_mask_t wr_mask2,
  output line_t      rd_line1,
  output line_t      rd_line2
);

  line_t      line_q [2][`DC_SETS];
  byte_mask_t mask [2];

  assign mask[0] = wr_mask1;
  assign mask[1] = wr_mask2;

  // Only enabled bytes change, the rest of the line is kept
  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      for (int b = 0; b < `DC_LINE_BYTES; b++) begin
        if (mask[w][b]) begin
          line_q[w][index][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
  end

  assign rd_line1 = line_q[0][index];
  assign rd_line2 = line_q[1][index];

endmodule

//--- verilog/dc_tag_store.sv
// ##############################
// Tag store
// Tag, valid and dirty per way, LRU bit per set
// ##############################

`timescale 1ns/100ps

`include "dcache_config.svh"

module dc_tag_store import dcache_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  index_t index,
  input  logic   fill_way1,
  input  logic   fill_way2,
  input  tag_t   fill_tag,
  input  logic   dirty_set1,
  input  logic   dirty_set2,
  input  logic   touch_way1,
  input  logic   touch_way2,
  output tag_t   tag1,
  output tag_t   tag2,
  output logic   valid1,
  output logic   valid2,
  output logic   dirty1,
  output logic   dirty2,
  output logic   repl_way2
);

  tag_t                tag_q [2][`DC_SETS];
  logic [`DC_SETS-1:0] valid_q [2];
  logic [`DC_SETS-1:0] dirty_q [2];
  logic [`DC_SETS-1:0] repl_q;
  logic [1:0]          fill_way;
  logic [1:0]          dirty_set;

  assign fill_way  = {fill_way2, fill_way1};
  assign dirty_set = {dirty_set2, dirty_set1};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < 2; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
      repl_q <= '0;
    end else begin
      for (int w = 0; w < 2; w++) begin
        // Fresh line from memory is clean
        if (fill_way[w]) begin
          valid_q[w][index] <= 1'b1;
          dirty_q[w][index] <= 1'b0;
        end else if (dirty_set[w]) begin
          dirty_q[w][index] <= 1'b1;
        end
      end
      // Point at the way not just used
      if (touch_way1) begin
        repl_q[index] <= 1'b1;
      end else if (touch_way2) begin
        repl_q[index] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      if (fill_way[w]) begin
        tag_q[w][index] <= fill_tag;
      end
    end
  end

  assign tag1      = tag_q[0][index];
  assign tag2      = tag_q[1][index];
  assign valid1    = valid_q[0][index];
  assign valid2    = valid_q[1][index];
  assign dirty1    = dirty_q[0][index];
  assign dirty2    = dirty_q[1][index];
  assign repl_way2 = repl_q[index];

  a_fill_vs_store: assert property (@(posedge clk) disable iff (!rst_n)
    (fill_way & dirty_set) == 2'b00);

endmodule

//--- verilog/dc_arbiter.sv
// ##############################
// Read/write arbiter
// Grants one access and holds it until done
// ##############################

`timescale 1ns/100ps

module dc_arbiter import dcache_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic v_mem_read,
  input  logic wr_fifo_empty,
  input  logic wr_fifo_to_be_full,
  input  logic mem_conflict,
  input  logic access_done,
  output logic ren,
  output logic wen
);

  arb_state_e state_q;
  arb_state_e state_d;
  logic       wr_pending;
  logic       wr_first;

  assign wr_pending = !wr_fifo_empty;

  // Stores go first when the FIFO is nearly full or hides a newer value
  assign wr_first = wr_fifo_to_be_full | mem_conflict | !v_mem_read;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ARB_IDLE: begin
        if (wr_pending && wr_first) begin
          state_d = ARB_WRITE;
        end else if (v_mem_read) begin
          state_d = ARB_READ;
        end
      end
      default: begin
        if (access_done) begin
          state_d = ARB_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ARB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign ren = (state_q == ARB_READ);
  assign wen = (state_q == ARB_WRITE);

  // A grant only covers a request that is still waiting
  a_grant_pending: assert property (@(posedge clk) disable iff (!rst_n)
    (!ren || v_mem_read) && (!wen || !wr_fifo_empty));

endmodule

//--- verilog/dcache_pkg.sv
// ##############################
// Data cache shared types
// Vector typedefs and arbiter states
// ##############################

`include "dcache_config.svh"

package dcache_pkg;

  typedef logic [`DC_ADDR_W-1:0]     addr_t;
  typedef logic [`DC_DATA_W-1:0]     data_t;
  typedef logic [`DC_LINE_W-1:0]     line_t;
  typedef logic [`DC_LINE_BYTES-1:0] byte_mask_t;
  typedef logic [`DC_TAG_W-1:0]      tag_t;
  typedef logic [`DC_INDEX_W-1:0]    index_t;

  // Byte position inside one line
  typedef logic [$clog2(`DC_LINE_BYTES)-1:0] offset_t;

  // 0 = 1 byte, 1 = 2 bytes, 2 = 4 bytes, 3 = 8 bytes
  typedef logic [1:0] size_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_READ,
    ARB_WRITE
  } arb_state_e;

endpackage

//--- include/dcache_config.svh
// ##############################
// Data cache configuration
// Sizes of lines, sets, tags and data words
// ##############################

`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Request side widths
`define DC_ADDR_W      32
`define DC_DATA_W      64

// Line geometry
`define DC_LINE_BYTES  16
`define DC_LINE_W      128

// Set and tag layout of the physical address
`define DC_SETS        16
`define DC_INDEX_W     4
`define DC_TAG_W       7
`define DC_TAG_LSB     8

// Anything above this bit is outside the cached space
`define DC_CACHED_MSB  14

`endif
